// File: run_sim.sh
#!/bin/sh
# build and run the issue stage testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module issue_tb -f vlog.f -o issue_sim

status=0
./obj_dir/issue_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "^Simulation passed$" sim.log; then
  echo "run passed, simulator exit status $status"
  exit 0
fi
echo "run failed, see sim.log"
exit 1

// File: source/exec_unit.sv
`default_nettype none

module exec_unit #(
    parameter int LATENCY = 1                        // cycles from issue to cdb, min 1
) (
    input  logic                            clk_i
  , input  logic                            reset_i
  , input  logic                            issue_v_i
  , input  logic [issue_pkg::OP_W-1:0]      op_i
  , input  logic [issue_pkg::TAG_W-1:0]     dest_i
  , input  logic [issue_pkg::WORD_SIZE-1:0] a_i
  , input  logic [issue_pkg::WORD_SIZE-1:0] b_i
  , output logic                            cdb_v_o
  , output logic [issue_pkg::TAG_W-1:0]     cdb_tag_o
  , output logic [issue_pkg::WORD_SIZE-1:0] cdb_data_o
);

  logic [issue_pkg::WORD_SIZE-1:0]              result;
  logic                                         op_legal;

  logic [LATENCY-1:0]                           v_q;      // stage valids
  logic [LATENCY-1:0][issue_pkg::TAG_W-1:0]     tag_q;
  logic [LATENCY-1:0][issue_pkg::WORD_SIZE-1:0] data_q;

  always_comb begin : compute
    op_legal = 1'b1;
    case (op_i)
      issue_pkg::OP_ADD: result = a_i + b_i;
      issue_pkg::OP_SUB: result = a_i - b_i;         // mod 2^32
      issue_pkg::OP_AND: result = a_i & b_i;
      issue_pkg::OP_OR:  result = a_i | b_i;
      issue_pkg::OP_XOR: result = a_i ^ b_i;
      issue_pkg::OP_MUL: result = a_i * b_i;         // low 32 bits only
      default: begin
        result   = '0;
        op_legal = 1'b0;                             // also catches x opcodes
      end
    endcase
  end

  // valid pipe, new work every cycle
  always_ff @(posedge clk_i) begin : valid_pipe
    if (reset_i) begin
      v_q <= '0;
    end else begin
      v_q[0] <= issue_v_i;
      for (int s = 1; s < LATENCY; s++) begin
        v_q[s] <= v_q[s-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin : data_pipe
    tag_q[0]  <= dest_i;
    data_q[0] <= result;
    for (int s = 1; s < LATENCY; s++) begin
      tag_q[s]  <= tag_q[s-1];
      data_q[s] <= data_q[s-1];
    end
  end

  assign cdb_v_o    = v_q[LATENCY-1];                // last stage drives the lane
  assign cdb_tag_o  = tag_q[LATENCY-1];
  assign cdb_data_o = data_q[LATENCY-1];

  // table must only hand over entries captured with a real opcode
  a_op_known : assert property (@(posedge clk_i) disable iff (reset_i)
    issue_v_i |-> op_legal);

endmodule

`default_nettype wire

// File: source/issue_pkg.sv
`default_nettype none

package issue_pkg;

  localparam int WORD_SIZE    = 32;                  // datapath width
  localparam int NUM_PHYS_REG = 32;                  // physical register count
  localparam int TAG_W        = 5;                   // log2 of NUM_PHYS_REG
  localparam int ISSUE_ENTRY  = 8;                   // issue table depth
  localparam int NUM_FU       = 2;                   // units, one cdb lane each

  localparam int FU_W  = $clog2(NUM_FU);             // unit select width
  localparam int IDX_W = $clog2(ISSUE_ENTRY);        // entry index width
  localparam int CNT_W = IDX_W + 1;                  // occupancy, counts up to full

  localparam int FU_ALU = 0;                         // lane 0
  localparam int FU_MUL = 1;                         // lane 1

  localparam int ALU_LATENCY = 1;
  localparam int MUL_LATENCY = 3;

  localparam int OP_W = 3;

  localparam logic [OP_W-1:0] OP_ADD = 3'd0;
  localparam logic [OP_W-1:0] OP_SUB = 3'd1;         // wraps
  localparam logic [OP_W-1:0] OP_AND = 3'd2;
  localparam logic [OP_W-1:0] OP_OR  = 3'd3;
  localparam logic [OP_W-1:0] OP_XOR = 3'd4;
  localparam logic [OP_W-1:0] OP_MUL = 3'd5;         // low word kept

  // second source word, either a full immediate or a register tag in the low bits
  typedef union packed {
    logic [WORD_SIZE-1:0] imm;                       // immediate view
    struct packed {
      logic [WORD_SIZE-TAG_W-1:0] unused;            // ignored when a tag
      logic [TAG_W-1:0]           tag;               // source register tag
    } tv;                                            // tag view
  } src2_u;

endpackage

`default_nettype wire

// File: source/issue_table.sv
`default_nettype none

module issue_table (
    input  logic                                                  clk_i
  , input  logic                                                  reset_i
  // rename side
  , input  logic                                                  valid_i
  , input  logic [issue_pkg::OP_W-1:0]                            opcode_i
  , input  logic [issue_pkg::FU_W-1:0]                            fu_i
  , input  logic [issue_pkg::TAG_W-1:0]                           dest_i
  , input  logic [issue_pkg::TAG_W-1:0]                           src1_i
  , input  issue_pkg::src2_u                                      src2_i
  , input  logic                                                  src2_imm_i
  , output logic                                                  ready_o
  // register file read and allocation
  , output logic [issue_pkg::TAG_W-1:0]                           rd_tag1_o
  , output logic [issue_pkg::TAG_W-1:0]                           rd_tag2_o
  , input  logic [issue_pkg::WORD_SIZE-1:0]                       rd_data1_i
  , input  logic [issue_pkg::WORD_SIZE-1:0]                       rd_data2_i
  , input  logic                                                  rd_v1_i
  , input  logic                                                  rd_v2_i
  , output logic                                                  alloc_v_o
  , output logic [issue_pkg::TAG_W-1:0]                           alloc_tag_o
  // to the units
  , output logic [issue_pkg::NUM_FU-1:0]                          issue_v_o
  , output logic [issue_pkg::OP_W-1:0]                            issue_op_o
  , output logic [issue_pkg::TAG_W-1:0]                           issue_dest_o
  , output logic [issue_pkg::WORD_SIZE-1:0]                       issue_a_o
  , output logic [issue_pkg::WORD_SIZE-1:0]                       issue_b_o
  // cdb snoop
  , input  logic [issue_pkg::NUM_FU-1:0]                          cdb_v_i
  , input  logic [issue_pkg::NUM_FU-1:0][issue_pkg::TAG_W-1:0]    cdb_tag_i
  , input  logic [issue_pkg::NUM_FU-1:0][issue_pkg::WORD_SIZE-1:0] cdb_data_i
);

  localparam int N = issue_pkg::ISSUE_ENTRY;

  logic [N-1:0]                           ent_v;     // entry holds an instruction
  logic [N-1:0]                           ent_rdy1;  // src1 data present
  logic [N-1:0]                           ent_rdy2;  // src2 data present
  logic [N-1:0][issue_pkg::OP_W-1:0]      ent_op;
  logic [N-1:0][issue_pkg::FU_W-1:0]      ent_fu;
  logic [N-1:0][issue_pkg::TAG_W-1:0]     ent_dest;
  logic [N-1:0][issue_pkg::TAG_W-1:0]     ent_tag1;
  logic [N-1:0][issue_pkg::TAG_W-1:0]     ent_tag2;
  logic [N-1:0][issue_pkg::WORD_SIZE-1:0] ent_d1;
  logic [N-1:0][issue_pkg::WORD_SIZE-1:0] ent_d2;

  logic [N-1:0][issue_pkg::IDX_W-1:0]     ord;       // slot 0 is oldest
  logic [N-1:0][issue_pkg::IDX_W-1:0]     ord_n;
  logic [N-1:0]                           ord_rdy;   // ready, in age order

  logic [issue_pkg::CNT_W-1:0]            cnt;       // occupancy
  logic [issue_pkg::CNT_W-1:0]            cnt_left;  // after this cycle's issue
  logic [issue_pkg::CNT_W-1:0]            cnt_n;

  logic [issue_pkg::IDX_W-1:0]            sel_slot;  // order slot picked
  logic [issue_pkg::IDX_W-1:0]            chosen;    // entry picked
  logic [issue_pkg::IDX_W-1:0]            new_loc;   // lowest free entry
  logic                                   sel_v;
  logic                                   accept;

  logic [issue_pkg::WORD_SIZE-1:0]        new_d2;
  logic                                   new_rdy2;

  assign accept      = valid_i & ready_o;
  assign rd_tag1_o   = src1_i;
  assign rd_tag2_o   = src2_i.tv.tag;                // read even for imm, ignored then
  assign alloc_v_o   = accept;                       // dest goes not-ready
  assign alloc_tag_o = dest_i;

  always_comb begin : src2_capture
    if (src2_imm_i) begin
      new_d2   = src2_i.imm;                         // imm valid right away
      new_rdy2 = 1'b1;
    end else begin
      new_d2   = rd_data2_i;
      new_rdy2 = rd_v2_i;
    end
  end

  // scan downward so the oldest ready slot wins
  always_comb begin : select_oldest
    sel_v    = 1'b0;
    sel_slot = '0;
    for (int s = N - 1; s >= 0; s--) begin
      ord_rdy[s] = (issue_pkg::CNT_W'(s) < cnt) && ent_rdy1[ord[s]] && ent_rdy2[ord[s]];
      if (ord_rdy[s]) begin
        sel_v    = 1'b1;
        sel_slot = issue_pkg::IDX_W'(s);
      end
    end
  end

  assign chosen = ord[sel_slot];

  always_comb begin : free_slot
    new_loc = '0;
    for (int e = N - 1; e >= 0; e--) begin
      if (!ent_v[e]) new_loc = issue_pkg::IDX_W'(e); // lowest free wins
    end
  end

  always_comb begin : fu_route
    for (int k = 0; k < issue_pkg::NUM_FU; k++) begin
      issue_v_o[k] = sel_v && (ent_fu[chosen] == issue_pkg::FU_W'(k));
    end
  end

  assign issue_op_o   = ent_op[chosen];
  assign issue_dest_o = ent_dest[chosen];
  assign issue_a_o    = ent_d1[chosen];
  assign issue_b_o    = ent_d2[chosen];

  assign cnt_left = cnt - issue_pkg::CNT_W'(sel_v);
  assign cnt_n    = cnt_left + issue_pkg::CNT_W'(accept);

  always_comb begin : order_next
    for (int j = 0; j < N; j++) begin
      if (sel_v && (issue_pkg::IDX_W'(j) >= sel_slot)) begin
        ord_n[j] = ord[(j + 1) % N];                 // close the gap, top slot is dead
      end else begin
        ord_n[j] = ord[j];
      end
    end
    if (accept) begin
      ord_n[cnt_left[issue_pkg::IDX_W-1:0]] = new_loc; // youngest goes behind survivors
    end
  end

  always_ff @(posedge clk_i) begin : control_regs
    if (reset_i) begin
      ent_v   <= '0;
      ord     <= '0;
      cnt     <= '0;
      ready_o <= 1'b0;                               // stays low one cycle past reset
    end else begin
      ord     <= ord_n;
      cnt     <= cnt_n;
      ready_o <= (cnt_n < issue_pkg::CNT_W'(N));
      if (sel_v)  ent_v[chosen]  <= 1'b0;
      if (accept) ent_v[new_loc] <= 1'b1;            // never the chosen entry
    end
  end

  always_ff @(posedge clk_i) begin : payload_regs
    for (int e = 0; e < N; e++) begin
      for (int k = 0; k < issue_pkg::NUM_FU; k++) begin
        if (ent_v[e] && !ent_rdy1[e] && cdb_v_i[k] && (cdb_tag_i[k] == ent_tag1[e])) begin
          ent_d1[e]   <= cdb_data_i[k];              // wakeup src1
          ent_rdy1[e] <= 1'b1;
        end
        if (ent_v[e] && !ent_rdy2[e] && cdb_v_i[k] && (cdb_tag_i[k] == ent_tag2[e])) begin
          ent_d2[e]   <= cdb_data_i[k];              // wakeup src2
          ent_rdy2[e] <= 1'b1;
        end
      end
    end
    if (accept) begin
      ent_op[new_loc]   <= opcode_i;
      ent_fu[new_loc]   <= fu_i;
      ent_dest[new_loc] <= dest_i;
      ent_tag1[new_loc] <= src1_i;
      ent_tag2[new_loc] <= src2_i.tv.tag;
      ent_d1[new_loc]   <= rd_data1_i;               // regfile already forwards cdb
      ent_rdy1[new_loc] <= rd_v1_i;
      ent_d2[new_loc]   <= new_d2;
      ent_rdy2[new_loc] <= new_rdy2;
    end
  end

  // at most one unit gets the pick, and only from a live entry
  a_issue_onehot : assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(issue_v_o) && ((issue_v_o == '0) || ent_v[chosen]));

  // valid bits must show a free entry whenever the renamer gets in
  a_no_full_accept : assert property (@(posedge clk_i) disable iff (reset_i)
    accept |-> !(&ent_v));

endmodule

`default_nettype wire

// File: source/issue_top.sv
`default_nettype none

module issue_top (
    input  logic                                                   clk_i
  , input  logic                                                   reset_i
  , input  logic                                                   valid_i
  , input  logic [issue_pkg::OP_W-1:0]                             opcode_i
  , input  logic [issue_pkg::FU_W-1:0]                             fu_i
  , input  logic [issue_pkg::TAG_W-1:0]                            dest_i
  , input  logic [issue_pkg::TAG_W-1:0]                            src1_i
  , input  issue_pkg::src2_u                                       src2_i
  , input  logic                                                   src2_imm_i
  , output logic                                                   ready_o
  , output logic [issue_pkg::NUM_FU-1:0]                           cdb_v_o
  , output logic [issue_pkg::NUM_FU-1:0][issue_pkg::TAG_W-1:0]     cdb_tag_o
  , output logic [issue_pkg::NUM_FU-1:0][issue_pkg::WORD_SIZE-1:0] cdb_data_o
);

  logic [issue_pkg::TAG_W-1:0]     rd_tag1, rd_tag2;
  logic [issue_pkg::WORD_SIZE-1:0] rd_data1, rd_data2;
  logic                            rd_v1, rd_v2;
  logic                            alloc_v;
  logic [issue_pkg::TAG_W-1:0]     alloc_tag;

  logic [issue_pkg::NUM_FU-1:0]    issue_v;          // one bit per unit
  logic [issue_pkg::OP_W-1:0]      issue_op;
  logic [issue_pkg::TAG_W-1:0]     issue_dest;
  logic [issue_pkg::WORD_SIZE-1:0] issue_a, issue_b;

  logic [issue_pkg::NUM_FU-1:0]                           cdb_v;
  logic [issue_pkg::NUM_FU-1:0][issue_pkg::TAG_W-1:0]     cdb_tag;
  logic [issue_pkg::NUM_FU-1:0][issue_pkg::WORD_SIZE-1:0] cdb_data;

  issue_table u_table (
      .clk_i, .reset_i
    , .valid_i, .opcode_i, .fu_i, .dest_i, .src1_i, .src2_i, .src2_imm_i, .ready_o
    , .rd_tag1_o(rd_tag1), .rd_tag2_o(rd_tag2)
    , .rd_data1_i(rd_data1), .rd_data2_i(rd_data2), .rd_v1_i(rd_v1), .rd_v2_i(rd_v2)
    , .alloc_v_o(alloc_v), .alloc_tag_o(alloc_tag)
    , .issue_v_o(issue_v), .issue_op_o(issue_op), .issue_dest_o(issue_dest)
    , .issue_a_o(issue_a), .issue_b_o(issue_b)
    , .cdb_v_i(cdb_v), .cdb_tag_i(cdb_tag), .cdb_data_i(cdb_data)
  );

  phys_reg_file u_prf (
      .clk_i, .reset_i
    , .rd_tag1_i(rd_tag1), .rd_tag2_i(rd_tag2)
    , .rd_data1_o(rd_data1), .rd_data2_o(rd_data2), .rd_v1_o(rd_v1), .rd_v2_o(rd_v2)
    , .alloc_v_i(alloc_v), .alloc_tag_i(alloc_tag)
    , .cdb_v_i(cdb_v), .cdb_tag_i(cdb_tag), .cdb_data_i(cdb_data)
  );

  // alu on lane 0
  exec_unit #(.LATENCY(issue_pkg::ALU_LATENCY)) u_alu (
      .clk_i, .reset_i
    , .issue_v_i(issue_v[issue_pkg::FU_ALU]), .op_i(issue_op), .dest_i(issue_dest)
    , .a_i(issue_a), .b_i(issue_b)
    , .cdb_v_o(cdb_v[issue_pkg::FU_ALU]), .cdb_tag_o(cdb_tag[issue_pkg::FU_ALU])
    , .cdb_data_o(cdb_data[issue_pkg::FU_ALU])
  );

  // multiplier on lane 1
  exec_unit #(.LATENCY(issue_pkg::MUL_LATENCY)) u_mul (
      .clk_i, .reset_i
    , .issue_v_i(issue_v[issue_pkg::FU_MUL]), .op_i(issue_op), .dest_i(issue_dest)
    , .a_i(issue_a), .b_i(issue_b)
    , .cdb_v_o(cdb_v[issue_pkg::FU_MUL]), .cdb_tag_o(cdb_tag[issue_pkg::FU_MUL])
    , .cdb_data_o(cdb_data[issue_pkg::FU_MUL])
  );

  assign cdb_v_o    = cdb_v;                         // lanes visible outside
  assign cdb_tag_o  = cdb_tag;
  assign cdb_data_o = cdb_data;

endmodule

`default_nettype wire

// File: source/phys_reg_file.sv
`default_nettype none

module phys_reg_file (
    input  logic                                                   clk_i
  , input  logic                                                   reset_i
  , input  logic [issue_pkg::TAG_W-1:0]                            rd_tag1_i
  , input  logic [issue_pkg::TAG_W-1:0]                            rd_tag2_i
  , output logic [issue_pkg::WORD_SIZE-1:0]                        rd_data1_o
  , output logic [issue_pkg::WORD_SIZE-1:0]                        rd_data2_o
  , output logic                                                   rd_v1_o
  , output logic                                                   rd_v2_o
  , input  logic                                                   alloc_v_i
  , input  logic [issue_pkg::TAG_W-1:0]                            alloc_tag_i
  , input  logic [issue_pkg::NUM_FU-1:0]                           cdb_v_i
  , input  logic [issue_pkg::NUM_FU-1:0][issue_pkg::TAG_W-1:0]     cdb_tag_i
  , input  logic [issue_pkg::NUM_FU-1:0][issue_pkg::WORD_SIZE-1:0] cdb_data_i
);

  logic [issue_pkg::NUM_PHYS_REG-1:0][issue_pkg::WORD_SIZE-1:0] regs;
  logic [issue_pkg::NUM_PHYS_REG-1:0]                           reg_rdy;   // value written back

  logic [1:0][issue_pkg::TAG_W-1:0]     rd_tag;      // port 1 at index 0
  logic [1:0][issue_pkg::WORD_SIZE-1:0] rd_data;
  logic [1:0]                           rd_v;
  logic                                 tag_clash;

  assign rd_tag = {rd_tag2_i, rd_tag1_i};

  always_comb begin : read_ports
    for (int p = 0; p < 2; p++) begin
      rd_data[p] = regs[rd_tag[p]];
      rd_v[p]    = reg_rdy[rd_tag[p]];
      for (int k = 0; k < issue_pkg::NUM_FU; k++) begin
        if (cdb_v_i[k] && (cdb_tag_i[k] == rd_tag[p])) begin
          rd_data[p] = cdb_data_i[k];                // same-cycle bypass
          rd_v[p]    = 1'b1;
        end
      end
    end
  end

  assign rd_data1_o = rd_data[0];
  assign rd_v1_o    = rd_v[0];
  assign rd_data2_o = rd_data[1];
  assign rd_v2_o    = rd_v[1];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      regs    <= '0;
      reg_rdy <= '1;                                 // all ready after reset
    end else begin
      for (int k = 0; k < issue_pkg::NUM_FU; k++) begin
        if (cdb_v_i[k]) begin
          regs[cdb_tag_i[k]]    <= cdb_data_i[k];
          reg_rdy[cdb_tag_i[k]] <= 1'b1;
        end
      end
      if (alloc_v_i) reg_rdy[alloc_tag_i] <= 1'b0;   // newest event wins
    end
  end

  always_comb begin : lane_clash
    tag_clash = 1'b0;
    for (int a = 0; a < issue_pkg::NUM_FU; a++) begin
      for (int b = a + 1; b < issue_pkg::NUM_FU; b++) begin
        if (cdb_v_i[a] && cdb_v_i[b] && (cdb_tag_i[a] == cdb_tag_i[b])) tag_clash = 1'b1;
      end
    end
  end

  // renamer and units together must keep cdb tags unique per cycle
  a_cdb_tag_unique : assert property (@(posedge clk_i) disable iff (reset_i)
    !tag_clash);

endmodule

`default_nettype wire

// File: testbench/issue_tb.sv
`default_nettype none

module issue_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 100;
  localparam int DRIVE_DLY    = 5;                   // after rising edge
  localparam int RAND_N       = 200;
  localparam int NUM_INSTR    = 13 + 8 + 3 + 18 + RAND_N; // every test's instructions
  localparam int WATCHDOG_CYC = NUM_INSTR * 40;
  localparam int STALL_LIMIT  = 200;                 // cycles on ready_o or drain

  logic                                                   clk_i = 1'b0;
  logic                                                   reset_i;
  logic                                                   valid_i;
  logic [issue_pkg::OP_W-1:0]                             opcode_i;
  logic [issue_pkg::FU_W-1:0]                             fu_i;
  logic [issue_pkg::TAG_W-1:0]                            dest_i;
  logic [issue_pkg::TAG_W-1:0]                            src1_i;
  issue_pkg::src2_u                                       src2_i;
  logic                                                   src2_imm_i;
  logic                                                   ready_o;
  logic [issue_pkg::NUM_FU-1:0]                           cdb_v_o;
  logic [issue_pkg::NUM_FU-1:0][issue_pkg::TAG_W-1:0]     cdb_tag_o;
  logic [issue_pkg::NUM_FU-1:0][issue_pkg::WORD_SIZE-1:0] cdb_data_o;

  logic [issue_pkg::NUM_PHYS_REG-1:0] pending;       // tag in flight
  logic [issue_pkg::WORD_SIZE-1:0]    model_reg [issue_pkg::NUM_PHYS_REG]; // latest per tag
  logic [issue_pkg::WORD_SIZE-1:0]    exp_data [issue_pkg::NUM_PHYS_REG];
  int                                 exp_lane [issue_pkg::NUM_PHYS_REG];
  int                                 done_seq [issue_pkg::NUM_PHYS_REG]; // completion order
  logic [issue_pkg::TAG_W-1:0]        next_tag;      // round-robin pointer
  int                                 err_count, check_count, sent_count, done_count;
  logic                               watch_full, saw_full;
  integer                             seed;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  issue_top u_dut (
      .clk_i, .reset_i
    , .valid_i, .opcode_i, .fu_i, .dest_i, .src1_i, .src2_i, .src2_imm_i, .ready_o
    , .cdb_v_o, .cdb_tag_o, .cdb_data_o
  );

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("ERR %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // opcode rules, 32-bit wrap everywhere
  function automatic logic [31:0] expect_result(input logic [2:0] op,
                                                input logic [31:0] a, input logic [31:0] b);
    case (op)
      issue_pkg::OP_ADD: return a + b;
      issue_pkg::OP_SUB: return a - b;
      issue_pkg::OP_AND: return a & b;
      issue_pkg::OP_OR:  return a | b;
      issue_pkg::OP_XOR: return a ^ b;
      default:           return a * b;               // low word of product
    endcase
  endfunction

  task automatic record_result(input int lane, input logic [4:0] tag, input logic [31:0] data);
    if (!pending[tag]) begin
      err_count++;
      $display("result on lane %0d for tag %0d, but nothing with that tag is in flight",
               lane, tag);
    end else begin
      check_value($sformatf("cdb_data_o[%0d] tag %0d", lane, tag), data, exp_data[tag]);
      check_value($sformatf("cdb lane of tag %0d", tag), 32'(lane), 32'(exp_lane[tag]));
      pending[tag]  = 1'b0;
      done_seq[tag] = done_count;
      done_count++;
    end
  endtask

  // lanes are registered, mid-cycle is a quiet point
  always @(negedge clk_i) begin : cdb_monitor
    if (!reset_i) begin
      for (int k = 0; k < issue_pkg::NUM_FU; k++) begin
        if (cdb_v_o[k]) record_result(k, cdb_tag_o[k], cdb_data_o[k]);
      end
      if (watch_full && !ready_o) saw_full = 1'b1;
    end
  end

  // renamer role, hands out a free dest and waits for the accept
  task automatic send_instr(input logic [2:0] op, input logic [4:0] src1,
                            input logic [31:0] src2, input logic is_imm,
                            output logic [4:0] dest);
    logic [31:0] a;
    logic [31:0] b;
    int          waited;
    dest = next_tag;
    while (pending[dest]) dest = dest + 1'b1;        // skip tags still in flight
    next_tag = dest + 1'b1;
    a = model_reg[src1];
    b = is_imm ? src2 : model_reg[src2[issue_pkg::TAG_W-1:0]];
    exp_data[dest]  = expect_result(op, a, b);
    exp_lane[dest]  = (op == issue_pkg::OP_MUL) ? issue_pkg::FU_MUL : issue_pkg::FU_ALU;
    model_reg[dest] = exp_data[dest];
    pending[dest]   = 1'b1;
    valid_i    = 1'b1;
    opcode_i   = op;
    fu_i       = issue_pkg::FU_W'(exp_lane[dest]);
    dest_i     = dest;
    src1_i     = src1;
    src2_imm_i = is_imm;
    src2_i.imm = src2;                               // as a tag, bits above it are junk
    waited = 0;
    @(negedge clk_i);
    while (!ready_o && waited < STALL_LIMIT) begin
      @(negedge clk_i);
      waited++;
    end
    if (!ready_o) begin
      err_count++;
      $display("ready_o stayed low for %0d cycles, instruction for tag %0d not accepted",
               STALL_LIMIT, dest);
    end else begin
      sent_count++;                                  // accepted on the coming edge
    end
    @(posedge clk_i);
    #(DRIVE_DLY);
    valid_i = 1'b0;
  endtask

  task automatic wait_idle;
    int cycles;
    cycles = 0;
    while (pending != '0 && cycles < STALL_LIMIT) begin
      @(posedge clk_i);
      #(DRIVE_DLY);
      cycles++;
    end
    if (pending != '0) begin
      err_count++;
      $display("results still missing after %0d cycles, pending tags %h", STALL_LIMIT, pending);
    end
  endtask

  task automatic reset_and_ready;
    int waited;
    reset_i = 1'b1;
    repeat (4) begin
      @(posedge clk_i);
      #(DRIVE_DLY);
      check_value("ready_o", 32'(ready_o), 32'd0);
      check_value("cdb_v_o", 32'(cdb_v_o), 32'd0);
    end
    reset_i = 1'b0;
    waited  = 0;
    while (!ready_o && waited < 4) begin
      @(posedge clk_i);
      #(DRIVE_DLY);
      waited++;
    end
    check_value("ready_o", 32'(ready_o), 32'd1);     // should rise shortly after reset
  endtask

  task automatic immediate_ops;
    logic [2:0] ops [6];
    logic [4:0] base;
    logic [4:0] t;
    ops = '{issue_pkg::OP_ADD, issue_pkg::OP_SUB, issue_pkg::OP_AND,
            issue_pkg::OP_OR, issue_pkg::OP_XOR, issue_pkg::OP_MUL};
    send_instr(issue_pkg::OP_ADD, 5'd0, 32'h89ab_cdef, 1'b1, base);
    for (int i = 0; i < 6; i++) begin
      send_instr(ops[i], base, 32'h0f0f_1234, 1'b1, t);
      send_instr(ops[i], base, 32'hffff_fff3, 1'b1, t); // sub wraps, mul overflows
    end
    wait_idle();
  endtask

  task automatic dependency_chains;
    logic [4:0] t [8];
    send_instr(issue_pkg::OP_ADD, 5'd0, 32'd7, 1'b1, t[0]);
    send_instr(issue_pkg::OP_MUL, t[0], 32'd13, 1'b1, t[1]);
    send_instr(issue_pkg::OP_ADD, t[1], 32'(t[0]), 1'b0, t[2]); // mul feeds alu
    send_instr(issue_pkg::OP_MUL, t[2], 32'(t[1]), 1'b0, t[3]);
    send_instr(issue_pkg::OP_SUB, t[3], 32'(t[2]), 1'b0, t[4]);
    send_instr(issue_pkg::OP_XOR, t[4], 32'(t[3]), 1'b0, t[5]);
    send_instr(issue_pkg::OP_MUL, t[5], 32'(t[5]), 1'b0, t[6]);
    send_instr(issue_pkg::OP_OR, t[6], 32'(t[0]), 1'b0, t[7]);
    wait_idle();
  endtask

  task automatic out_of_order_done;
    logic [4:0] src;
    logic [4:0] tm;
    logic [4:0] ta;
    send_instr(issue_pkg::OP_ADD, 5'd3, 32'd100, 1'b1, src);
    wait_idle();                                     // both sources ready below
    send_instr(issue_pkg::OP_MUL, src, 32'd7, 1'b1, tm);
    send_instr(issue_pkg::OP_ADD, src, 32'd1, 1'b1, ta);
    wait_idle();
    check_value("add done before mul", 32'(done_seq[ta] < done_seq[tm]), 32'd1);
  endtask

  task automatic full_table_stall;
    logic [4:0] m [4];
    logic [4:0] t;
    saw_full   = 1'b0;
    watch_full = 1'b1;
    send_instr(issue_pkg::OP_MUL, 5'd2, 32'd3, 1'b1, m[0]);
    for (int i = 1; i < 4; i++) begin
      send_instr(issue_pkg::OP_MUL, m[i-1], 32'd5, 1'b1, m[i]); // slow chain
    end
    for (int i = 0; i < 14; i++) begin
      if (i % 2 == 1) send_instr(issue_pkg::OP_SUB, m[3], 32'(m[2]), 1'b0, t);
      else            send_instr(issue_pkg::OP_ADD, m[3], 32'(i), 1'b1, t);
    end
    wait_idle();
    watch_full = 1'b0;
    check_value("ready_o low while full", 32'(saw_full), 32'd1);
  endtask

  task automatic random_mix;
    logic [31:0] r;
    logic [31:0] r2;
    logic [2:0]  op;
    logic [4:0]  t;
    for (int i = 0; i < RAND_N; i++) begin
      r  = $random(seed);
      r2 = $random(seed);                            // imm, or tag with junk above
      op = issue_pkg::OP_W'(r[7:0] % 6);
      send_instr(op, r[13:9], r2, r[8], t);
      if (r[15:14] == 2'd0) begin
        @(posedge clk_i);                            // idle gap now and then
        #(DRIVE_DLY);
      end
    end
    wait_idle();
  endtask

  task automatic print_counts;
    $display("checks %0d, errors %0d, accepted %0d, completed %0d",
             check_count, err_count, sent_count, done_count);
  endtask

  initial begin : watchdog
    #(WATCHDOG_CYC * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYC);
    print_counts();
    $display("Simulation failed");
    $finish;
  end

  initial begin : main
    seed       = 32'h17f32b07;
    reset_i    = 1'b1;
    valid_i    = 1'b0;
    opcode_i   = '0;
    fu_i       = '0;
    dest_i     = '0;
    src1_i     = '0;
    src2_i.imm = '0;
    src2_imm_i = 1'b0;
    pending    = '0;
    next_tag   = 5'd1;
    watch_full = 1'b0;
    saw_full   = 1'b0;
    for (int i = 0; i < issue_pkg::NUM_PHYS_REG; i++) begin
      model_reg[i] = '0;                             // registers clear at reset
      done_seq[i]  = 0;
    end
    reset_and_ready();
    immediate_ops();
    dependency_chains();
    out_of_order_done();
    full_table_stall();
    random_mix();
    check_value("completed count", 32'(done_count), 32'(sent_count));
    print_counts();
    if (err_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
source/issue_pkg.sv
source/issue_table.sv
source/phys_reg_file.sv
source/exec_unit.sv
source/issue_top.sv
testbench/issue_tb.sv
